// File: src/nou_pkg.sv
// Shared widths, command field positions and codes of the NOU control pipeline.
// Modules refer to these by scoped name.
package nou_pkg;

   // Request and response words
   localparam int NOU_XOCC_CMD_WIDTH = 32;
   typedef logic [NOU_XOCC_CMD_WIDTH-1:0] nou_cmd_t;

   localparam int NOU_SID_WIDTH = 4;
   typedef logic [NOU_SID_WIDTH-1:0] nou_sid_t;

   localparam int NOU_PKT_ID_WIDTH = 8;
   typedef logic [NOU_PKT_ID_WIDTH-1:0] nou_pkt_id_t;

   localparam int NOU_REQ_TYPE_WIDTH = 4;
   typedef logic [NOU_REQ_TYPE_WIDTH-1:0] nou_req_type_t;

   // Field positions, shared by request and response words
   localparam int REQ_TYPE_LSB   = 28;
   localparam int SID_LSB        = 24;
   localparam int PKT_ID_LSB     = 16;
   // Response only
   localparam int RSP_STATUS_POS = 15;
   localparam int RSP_ERR_LSB    = 12;

   // Request types, all other codes are invalid
   localparam nou_req_type_t REQ_WL_ADD = 4'd1;
   localparam nou_req_type_t REQ_WL_DEL = 4'd2;
   localparam nou_req_type_t REQ_WL_CHK = 4'd3;

   // Whitelist operation after decode
   typedef enum logic [1:0] {
      OP_ADD,
      OP_DEL,
      OP_CHK,
      OP_BAD
   } nou_op_e;

   // Error codes
   localparam int NOU_ERR_WIDTH = 3;
   typedef logic [NOU_ERR_WIDTH-1:0] nou_err_t;

   localparam nou_err_t ERR_NONE    = 3'd0;
   localparam nou_err_t ERR_FULL    = 3'd1;
   localparam nou_err_t ERR_EXIST   = 3'd2;
   localparam nou_err_t ERR_MISS    = 3'd3;
   localparam nou_err_t ERR_BAD_REQ = 3'd4;

endpackage

// File: src/nou_if.sv
// Stage-to-stage groups inside the NOU: whitelist requests from decode
// and unit results into retire.

// Decode to packet whitelist unit, held stable until ack
interface nou_wl_req_if;
   logic                   vld;
   logic                   ack;
   nou_pkg::nou_sid_t      sid;
   nou_pkg::nou_req_type_t req_type;
   nou_pkg::nou_op_e       op;
   nou_pkg::nou_pkt_id_t   pkt_id;

   modport decode (
      output vld, sid, req_type, op, pkt_id,
      input  ack
   );

   modport pwu (
      input  vld, sid, req_type, op, pkt_id,
      output ack
   );
endinterface

// Unit result to retire, held while keep is high
interface nou_unit_rsp_if;
   logic                   vld;
   logic                   keep;
   nou_pkg::nou_sid_t      sid;
   nou_pkg::nou_req_type_t req_type;
   nou_pkg::nou_pkt_id_t   pkt_id;
   logic                   status;
   nou_pkg::nou_err_t      err;

   modport unit (
      output vld, sid, req_type, pkt_id, status, err,
      input  keep
   );

   modport retire (
      input  vld, sid, req_type, pkt_id, status, err,
      output keep
   );
endinterface

// File: src/nou_fetch.sv
// Fetch stage that pops the external request FIFO into one holding register
// and offers the command to decode.
module nou_fetch (
   input  logic              nou_clk,
   input  logic              rst_n,
   input  logic              req_fifo_nou_empty_f0,
   input  nou_pkg::nou_cmd_t req_fifo_nou_data_f1,
   input  logic              decode_ack,
   output logic              nou_req_fifo_rd_en_f0,
   output logic              fetch_vld,
   output nou_pkg::nou_cmd_t fetch_cmd
);

   // Read in flight whose data shows up on f1 this cycle
   logic rd_pend;

   // At most one read outstanding and only when the slot is free on arrival
   assign nou_req_fifo_rd_en_f0 = !req_fifo_nou_empty_f0 && !rd_pend &&
                                  (!fetch_vld || decode_ack);

   always_ff @(posedge nou_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend   <= 1'b0;
         fetch_vld <= 1'b0;
      end else begin
         rd_pend <= nou_req_fifo_rd_en_f0;
         if (rd_pend) begin
            fetch_vld <= 1'b1;
         end else if (decode_ack) begin
            fetch_vld <= 1'b0;
         end
      end
   end

   // Holding register
   always_ff @(posedge nou_clk) begin
      if (rd_pend) begin
         fetch_cmd <= req_fifo_nou_data_f1;
      end
   end

   // A landing read never overwrites a command that decode has not taken
   a_no_overwrite: assert property (
      @(posedge nou_clk) disable iff (!rst_n)
      rd_pend |-> !fetch_vld || decode_ack
   );

endmodule

// File: src/nou_decode.sv
// Decode stage: registers one fetched command, splits out its fields and
// turns the request type into a whitelist operation.
module nou_decode (
   input  logic              nou_clk,
   input  logic              rst_n,
   input  logic              fetch_vld,
   input  nou_pkg::nou_cmd_t fetch_cmd,
   output logic              decode_ack,
   nou_wl_req_if.decode      req
);

   logic                   dec_vld;
   nou_pkg::nou_cmd_t      cmd_q;
   nou_pkg::nou_req_type_t req_type;

   // Take a new command when empty or when pwu takes the current one
   assign decode_ack = fetch_vld && (!dec_vld || req.ack);

   always_ff @(posedge nou_clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_vld <= 1'b0;
      end else if (decode_ack) begin
         dec_vld <= 1'b1;
      end else if (req.ack) begin
         dec_vld <= 1'b0;
      end
   end

   always_ff @(posedge nou_clk) begin
      if (decode_ack) begin
         cmd_q <= fetch_cmd;
      end
   end

   // Field extraction
   assign req_type     = cmd_q[nou_pkg::REQ_TYPE_LSB +: nou_pkg::NOU_REQ_TYPE_WIDTH];
   assign req.vld      = dec_vld;
   assign req.req_type = req_type;
   assign req.sid      = cmd_q[nou_pkg::SID_LSB +: nou_pkg::NOU_SID_WIDTH];
   assign req.pkt_id   = cmd_q[nou_pkg::PKT_ID_LSB +: nou_pkg::NOU_PKT_ID_WIDTH];

   always_comb begin
      case (req_type)
         nou_pkg::REQ_WL_ADD: req.op = nou_pkg::OP_ADD;
         nou_pkg::REQ_WL_DEL: req.op = nou_pkg::OP_DEL;
         nou_pkg::REQ_WL_CHK: req.op = nou_pkg::OP_CHK;
         // Unknown codes still pass through to get an error response
         default:             req.op = nou_pkg::OP_BAD;
      endcase
   end

endmodule

// File: src/nou_pwu.sv
// Packet whitelist unit: small content-addressed table of packet IDs.
// Runs add, delete and check, and holds each result for retire.
module nou_pwu #(
   parameter int WL_ENTRIES = 8
) (
   input  logic           nou_clk,
   input  logic           rst_n,
   nou_wl_req_if.pwu      req,
   nou_unit_rsp_if.unit   rsp
);

   localparam int IDX_W = (WL_ENTRIES > 1) ? $clog2(WL_ENTRIES) : 1;

   logic [WL_ENTRIES-1:0] wl_vld;
   nou_pkg::nou_pkt_id_t  wl_id [WL_ENTRIES];

   logic [WL_ENTRIES-1:0] match;
   logic                  hit;
   logic                  free_hit;
   logic [IDX_W-1:0]      free_idx;
   logic                  nxt_status;
   nou_pkg::nou_err_t     nxt_err;

   // CAM lookup
   always_comb begin
      for (int i = 0; i < WL_ENTRIES; i++) begin
         match[i] = wl_vld[i] && (wl_id[i] == req.pkt_id);
      end
   end
   assign hit = |match;

   // Lowest free entry wins
   always_comb begin
      free_hit = 1'b0;
      free_idx = '0;
      for (int i = WL_ENTRIES - 1; i >= 0; i--) begin
         if (!wl_vld[i]) begin
            free_hit = 1'b1;
            free_idx = IDX_W'(i);
         end
      end
   end

   always_comb begin
      nxt_status = 1'b0;
      nxt_err    = nou_pkg::ERR_NONE;
      case (req.op)
         nou_pkg::OP_ADD: begin
            if (hit) begin
               nxt_err = nou_pkg::ERR_EXIST;
            end else if (!free_hit) begin
               nxt_err = nou_pkg::ERR_FULL;
            end else begin
               nxt_status = 1'b1;
            end
         end
         nou_pkg::OP_DEL: begin
            nxt_status = hit;
            nxt_err    = hit ? nou_pkg::ERR_NONE : nou_pkg::ERR_MISS;
         end
         // Miss is not an error
         nou_pkg::OP_CHK: nxt_status = hit;
         default:         nxt_err = nou_pkg::ERR_BAD_REQ;
      endcase
   end

   // Result slot free or draining this cycle
   assign req.ack = req.vld && (!rsp.vld || !rsp.keep);

   always_ff @(posedge nou_clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp.vld <= 1'b0;
         wl_vld  <= '0;
      end else begin
         if (req.ack) begin
            rsp.vld <= 1'b1;
         end else if (!rsp.keep) begin
            rsp.vld <= 1'b0;
         end
         if (req.ack && req.op == nou_pkg::OP_ADD && !hit && free_hit) begin
            wl_vld[free_idx] <= 1'b1;
         end else if (req.ack && req.op == nou_pkg::OP_DEL) begin
            wl_vld <= wl_vld & ~match;
         end
      end
   end

   always_ff @(posedge nou_clk) begin
      if (req.ack) begin
         rsp.sid      <= req.sid;
         rsp.req_type <= req.req_type;
         rsp.pkt_id   <= req.pkt_id;
         rsp.status   <= nxt_status;
         rsp.err      <= nxt_err;
      end
      if (req.ack && req.op == nou_pkg::OP_ADD && !hit && free_hit) begin
         wl_id[free_idx] <= req.pkt_id;
      end
   end

   // Table never holds a packet ID twice
   a_unique_id: assert property (
      @(posedge nou_clk) disable iff (!rst_n)
      req.vld |-> $onehot0(match)
   );

endmodule

// File: src/nou_retire.sv
// Retire stage that formats unit results as response words and writes them
// into the external response FIFO when it has room.
module nou_retire (
   input  logic              nou_clk,
   input  logic              rst_n,
   input  logic              rsp_fifo_nou_full,
   nou_unit_rsp_if.retire    rsp,
   output logic              nou_rsp_fifo_wr_en,
   output nou_pkg::nou_cmd_t nou_rsp_fifo_data
);

   // Full FIFO stalls the unit
   assign rsp.keep           = rsp_fifo_nou_full;
   assign nou_rsp_fifo_wr_en = rsp.vld && !rsp_fifo_nou_full;

   // Response word with the unused low bits at zero
   always_comb begin
      nou_rsp_fifo_data = '0;
      nou_rsp_fifo_data[nou_pkg::REQ_TYPE_LSB +: nou_pkg::NOU_REQ_TYPE_WIDTH] =
         rsp.req_type;
      nou_rsp_fifo_data[nou_pkg::SID_LSB +: nou_pkg::NOU_SID_WIDTH] = rsp.sid;
      nou_rsp_fifo_data[nou_pkg::PKT_ID_LSB +: nou_pkg::NOU_PKT_ID_WIDTH] =
         rsp.pkt_id;
      nou_rsp_fifo_data[nou_pkg::RSP_STATUS_POS] = rsp.status;
      nou_rsp_fifo_data[nou_pkg::RSP_ERR_LSB +: nou_pkg::NOU_ERR_WIDTH] = rsp.err;
   end

   // A stalled result must still be there, unchanged, in the next cycle
   a_hold_stall: assert property (
      @(posedge nou_clk) disable iff (!rst_n)
      rsp.vld && rsp.keep |=> rsp.vld && $stable(rsp.sid) && $stable(rsp.pkt_id)
                              && $stable(rsp.err) && $stable(rsp.req_type)
                              && $stable(rsp.status)
   );

endmodule

// File: src/nou.sv
// NOU control pipeline top level: fetch, decode, packet whitelist unit
// and retire between the request and response FIFOs.
module nou #(
   parameter int WL_ENTRIES = 8
) (
   input  logic              nou_clk,
   input  logic              rst_n,

   // Request FIFO
   input  nou_pkg::nou_cmd_t req_fifo_nou_data_f1,
   input  logic              req_fifo_nou_empty_f0,
   output logic              nou_req_fifo_rd_en_f0,

   // Response FIFO
   input  logic              rsp_fifo_nou_full,
   output logic              nou_rsp_fifo_wr_en,
   output nou_pkg::nou_cmd_t nou_rsp_fifo_data
);

   logic              fetch_vld;
   nou_pkg::nou_cmd_t fetch_cmd;
   logic              decode_ack;

   nou_wl_req_if   wl_req_if ();
   nou_unit_rsp_if unit_rsp_if ();

   nou_fetch u_fetch (
      .nou_clk               (nou_clk),
      .rst_n                 (rst_n),
      .req_fifo_nou_empty_f0 (req_fifo_nou_empty_f0),
      .req_fifo_nou_data_f1  (req_fifo_nou_data_f1),
      .decode_ack            (decode_ack),
      .nou_req_fifo_rd_en_f0 (nou_req_fifo_rd_en_f0),
      .fetch_vld             (fetch_vld),
      .fetch_cmd             (fetch_cmd)
   );

   nou_decode u_decode (
      .nou_clk    (nou_clk),
      .rst_n      (rst_n),
      .fetch_vld  (fetch_vld),
      .fetch_cmd  (fetch_cmd),
      .decode_ack (decode_ack),
      .req        (wl_req_if)
   );

   nou_pwu #(
      .WL_ENTRIES (WL_ENTRIES)
   ) u_pwu (
      .nou_clk (nou_clk),
      .rst_n   (rst_n),
      .req     (wl_req_if),
      .rsp     (unit_rsp_if)
   );

   nou_retire u_retire (
      .nou_clk            (nou_clk),
      .rst_n              (rst_n),
      .rsp_fifo_nou_full  (rsp_fifo_nou_full),
      .rsp                (unit_rsp_if),
      .nou_rsp_fifo_wr_en (nou_rsp_fifo_wr_en),
      .nou_rsp_fifo_data  (nou_rsp_fifo_data)
   );

endmodule

// File: tb/nou_model.svh
// Whitelist reference model for the NOU testbench, included inside tb_nou.
// Tracks which packet IDs are present and predicts each response word in request order.
`ifndef NOU_MODEL_SVH
`define NOU_MODEL_SVH

// One flag per possible packet ID, plus the number of IDs held
bit wl_present [256];
int wl_count = 0;

function automatic nou_pkg::nou_cmd_t predict_response(input nou_pkg::nou_cmd_t cmd);
   nou_pkg::nou_req_type_t req_type;
   nou_pkg::nou_pkt_id_t   pkt_id;
   logic                   status;
   nou_pkg::nou_err_t      err;
   nou_pkg::nou_cmd_t      rsp;

   req_type = cmd[31:28];
   pkt_id   = cmd[23:16];
   status   = 1'b0;
   err      = nou_pkg::ERR_NONE;
   case (req_type)
      nou_pkg::REQ_WL_ADD: begin
         // A present ID is reported before a full table
         if (wl_present[pkt_id]) begin
            err = nou_pkg::ERR_EXIST;
         end else if (wl_count == WL_ENTRIES) begin
            err = nou_pkg::ERR_FULL;
         end else begin
            wl_present[pkt_id] = 1'b1;
            wl_count++;
            status = 1'b1;
         end
      end
      nou_pkg::REQ_WL_DEL: begin
         if (wl_present[pkt_id]) begin
            wl_present[pkt_id] = 1'b0;
            wl_count--;
            status = 1'b1;
         end else begin
            err = nou_pkg::ERR_MISS;
         end
      end
      nou_pkg::REQ_WL_CHK: status = wl_present[pkt_id];
      default:             err = nou_pkg::ERR_BAD_REQ;
   endcase

   // Type, SID and packet ID echoed, zeros below the error code
   rsp        = '0;
   rsp[31:24] = cmd[31:24];
   rsp[23:16] = pkt_id;
   rsp[15]    = status;
   rsp[14:12] = err;
   return rsp;
endfunction

`endif

// File: tb/tb_nou.sv
// Testbench for the NOU pipeline that models the request and response FIFOs and
// checks random whitelist traffic under back-pressure against a reference model.
module tb_nou;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WL_ENTRIES     = 4;
   localparam int NUM_REQS       = 300;
   localparam int TIMEOUT_CYCLES = NUM_REQS * 40;
   localparam int DRAIN_CYCLES   = 20;

   logic              nou_clk = 1'b0;
   logic              rst_n;
   nou_pkg::nou_cmd_t req_fifo_nou_data_f1;
   logic              req_fifo_nou_empty_f0;
   logic              nou_req_fifo_rd_en_f0;
   logic              rsp_fifo_nou_full;
   logic              nou_rsp_fifo_wr_en;
   nou_pkg::nou_cmd_t nou_rsp_fifo_data;

   // Request FIFO contents and predicted responses in request order
   nou_pkg::nou_cmd_t req_q[$];
   nou_pkg::nou_cmd_t exp_q[$];
   int                rsp_count = 0;
   int unsigned       lcg_state = 31;

   `include "nou_model.svh"

   nou #(
      .WL_ENTRIES (WL_ENTRIES)
   ) nou_inst (
      .nou_clk               (nou_clk),
      .rst_n                 (rst_n),
      .req_fifo_nou_data_f1  (req_fifo_nou_data_f1),
      .req_fifo_nou_empty_f0 (req_fifo_nou_empty_f0),
      .nou_req_fifo_rd_en_f0 (nou_req_fifo_rd_en_f0),
      .rsp_fifo_nou_full     (rsp_fifo_nou_full),
      .nou_rsp_fifo_wr_en    (nou_rsp_fifo_wr_en),
      .nou_rsp_fifo_data     (nou_rsp_fifo_data)
   );

   always #5 nou_clk = ~nou_clk;

   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   task automatic check_value(input string name, input nou_pkg::nou_cmd_t got,
                              input nou_pkg::nou_cmd_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   // Types 0 to 4 so that some requests are invalid
   task automatic load_requests();
      nou_pkg::nou_cmd_t cmd;
      for (int i = 0; i < NUM_REQS; i++) begin
         cmd        = '0;
         cmd[31:28] = 4'(next_rand() % 5);
         cmd[27:24] = 4'(i);
         cmd[23:16] = 8'(next_rand() % 8);
         // Unused low bits carry junk
         cmd[15:0]  = 16'(next_rand());
         req_q.push_back(cmd);
         exp_q.push_back(predict_response(cmd));
      end
   endtask

   // Request FIFO pops on rd_en with data one cycle later
   always @(posedge nou_clk) begin
      if (rst_n && req_fifo_nou_empty_f0) begin
         check_value("nou_req_fifo_rd_en_f0", 32'(nou_req_fifo_rd_en_f0), 32'd0);
      end
      if (rst_n && nou_req_fifo_rd_en_f0) begin
         req_fifo_nou_data_f1 <= req_q.pop_front();
      end
      req_fifo_nou_empty_f0 <= !rst_n || req_q.size() == 0;
      // Random back-pressure from the response FIFO
      rsp_fifo_nou_full     <= (next_rand() % 10) < 3;
   end

   // Response FIFO side
   always @(posedge nou_clk) begin
      if (rst_n) begin
         if (rsp_fifo_nou_full) begin
            check_value("nou_rsp_fifo_wr_en", 32'(nou_rsp_fifo_wr_en), 32'd0);
         end
         if (nou_rsp_fifo_wr_en) begin
            if (exp_q.size() == 0) begin
               $display("Response written at %0t ns with no request left to answer", $time);
               $display("TB FAILED");
               $fatal(1);
            end else begin
               check_value("nou_rsp_fifo_data", nou_rsp_fifo_data, exp_q.pop_front());
               rsp_count++;
            end
         end
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge nou_clk);
      $display("Timeout after %0d cycles with %0d of %0d responses", TIMEOUT_CYCLES,
               rsp_count, NUM_REQS);
      $display("TB FAILED");
      $fatal(1);
   end

   initial begin
      rst_n                 = 1'b0;
      req_fifo_nou_empty_f0 = 1'b1;
      req_fifo_nou_data_f1  = '0;
      rsp_fifo_nou_full     = 1'b0;
      load_requests();
      repeat (4) @(posedge nou_clk);
      rst_n <= 1'b1;
      wait (rsp_count == NUM_REQS);
      // Extra cycles to catch a duplicated response
      repeat (DRAIN_CYCLES) @(posedge nou_clk);
      if (rsp_count == NUM_REQS && exp_q.size() == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("Got %0d responses for %0d requests", rsp_count, NUM_REQS);
         $display("TB FAILED");
         $fatal(1);
      end
   end

endmodule

// File: nou.f
+incdir+tb
src/nou_pkg.sv
src/nou_if.sv
src/nou_fetch.sv
src/nou_decode.sv
src/nou_pwu.sv
src/nou_retire.sv
src/nou.sv
tb/tb_nou.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the NOU testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_nou -f nou.f -o tb_nou

./obj_dir/tb_nou
